// File: controlSequencer.f
seqPkg.sv
instrDecoder.sv
decodeRegister.sv
regListScanner.sv
microSequencer.sv
controlSequencer.sv
controlSequencerTb.sv

// File: controlSequencer.sv
`timescale 1ns/10ps

module controlSequencer (
	input logic clk,
	input logic rstN,
	input logic [seqPkg::irWidth-1:0] ir,
	input logic cond,
	input logic moc,
	output seqPkg::microStateT state,
	output seqPkg::addrModeT addrMode,
	output seqPkg::multiModeT multiMode,
	output logic byteOp,
	output logic subtract,
	output logic regOffset,
	output logic writeBack,
	output logic [seqPkg::regNumWidth-1:0] regNum
);

	seqPkg::instrClassT instrClass;
	logic regForm;
	logic setFlags;
	logic isLoad;
	logic loadFields; // Decode accepted, capture fields
	logic advance;
	logic listEmpty;
	logic lastReg;

	instrDecoder instrDecoder_i (
		.ir(ir),
		.instrClass(instrClass),
		.regForm(regForm),
		.setFlags(setFlags),
		.isLoad(isLoad)
	);

	decodeRegister decodeRegister_i (
		.clk(clk),
		.rstN(rstN),
		.loadFields(loadFields),
		.ir(ir),
		.addrMode(addrMode),
		.multiMode(multiMode),
		.byteOp(byteOp),
		.subtract(subtract),
		.regOffset(regOffset),
		.writeBack(writeBack)
	);

	regListScanner regListScanner_i (
		.clk(clk),
		.rstN(rstN),
		.loadFields(loadFields),
		.advance(advance),
		.ir(ir),
		.regNum(regNum),
		.listEmpty(listEmpty),
		.lastReg(lastReg)
	);

	microSequencer microSequencer_i (
		.clk(clk),
		.rstN(rstN),
		.cond(cond),
		.moc(moc),
		.instrClass(instrClass),
		.regForm(regForm),
		.setFlags(setFlags),
		.isLoad(isLoad),
		.listEmpty(listEmpty),
		.lastReg(lastReg),
		.state(state),
		.loadFields(loadFields),
		.advance(advance)
	);

endmodule

// File: controlSequencerTb.sv
`timescale 1ns/10ps

module controlSequencerTb;

	localparam int clkPeriod = 4;
	localparam int numInstr = 400;
	localparam int maxCycles = 60; // Worst case per instruction

	logic clk;
	logic rstN;
	logic [31:0] ir;
	logic cond;
	logic moc;
	seqPkg::microStateT state;
	seqPkg::addrModeT addrMode;
	seqPkg::multiModeT multiMode;
	logic byteOp;
	logic subtract;
	logic regOffset;
	logic writeBack;
	logic [3:0] regNum;

	int seed = 78879;
	int checkCount [1:6];
	int errorCount [1:6];

	// Reference model state
	seqPkg::microStateT expState;
	seqPkg::microStateT prevState;
	seqPkg::microStateT nextExp;
	seqPkg::addrModeT expAddrMode;
	seqPkg::multiModeT expMultiMode;
	logic expByte;
	logic expSub;
	logic expRegOff;
	logic expWb;
	logic [15:0] mask; // Registers the model still expects
	logic [31:0] r;
	logic finished;
	int instrCount;
	int curBeh;
	int beh;
	int totalChecks;
	int totalErrors;

	controlSequencer controlSequencer_i (
		.clk(clk),
		.rstN(rstN),
		.ir(ir),
		.cond(cond),
		.moc(moc),
		.state(state),
		.addrMode(addrMode),
		.multiMode(multiMode),
		.byteOp(byteOp),
		.subtract(subtract),
		.regOffset(regOffset),
		.writeBack(writeBack),
		.regNum(regNum)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(numInstr * maxCycles * clkPeriod);
		$display("Watchdog expired before all instructions completed");
		$display("Verification failed");
		$finish;
	end

	task automatic checkValue(input int b, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount[b]++;
		assert (got === exp) else begin
			$display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, got);
			errorCount[b]++;
		end
	endtask

	function automatic logic [3:0] lowestBit(input logic [15:0] m);
		logic [3:0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = 0; i < 16; i++) begin
			if (m[i] && !found) begin
				n = i[3:0];
				found = 1'b1;
			end
		end
		return n;
	endfunction

	// Random instruction of one group, returns the behavior it exercises
	task automatic makeInstr(output logic [31:0] word, output int b);
		logic [31:0] pick;
		pick = $random(seed);
		word = $random(seed);
		case (pick[2:0])
			3'd0: begin word[27:25] = 3'b001; b = 3; end
			3'd1: begin word[27:25] = 3'b000; word[4] = 1'b0; b = 3; end
			3'd2: begin
				word[27:25] = {2'b00, pick[3]}; // Test opcode, either operand form
				word[24:21] = {3'b100, pick[4]};
				word[4] = 1'b0;
				b = 3;
			end
			3'd3: begin word[27:25] = 3'b010; b = 4; end
			3'd4: begin word[27:25] = 3'b011; word[4] = 1'b0; b = 4; end
			3'd5: begin
				word[27:25] = 3'b100;
				if (pick[6:4] == 3'd0)
					word[15:0] = '0;
				else if (pick[6:4] == 3'd1)
					word[15:0] = 16'h0001 << pick[11:8];
				b = 5;
			end
			3'd6: begin word[27:25] = 3'b101; b = 6; end
			default: begin
				// Dropped groups and unused class codes
				case (pick[5:4])
					2'd0: word[27:25] = 3'b111;
					2'd1: begin word[27:25] = 3'b000; word[4] = 1'b1; end
					2'd2: begin word[27:25] = 3'b011; word[4] = 1'b1; end
					default: word[27:25] = 3'b110;
				endcase
				b = 2;
			end
		endcase
	endtask

	function automatic seqPkg::microStateT decodeTarget(input logic [31:0] word, input logic c);
		logic test;
		test = (word[24:21] == 4'd8) || (word[24:21] == 4'd9);
		if (!c)
			return seqPkg::stFetch1;
		case (word[27:25])
			3'b000: begin
				if (word[4])
					return seqPkg::stFetch1;
				if (test)
					return seqPkg::stTestReg;
				return word[20] ? seqPkg::stDpRegS : seqPkg::stDpReg;
			end
			3'b001: begin
				if (test)
					return seqPkg::stTestImm;
				return word[20] ? seqPkg::stDpImmS : seqPkg::stDpImm;
			end
			3'b010: return word[20] ? seqPkg::stLdAddr : seqPkg::stStAddr;
			3'b011: begin
				if (word[4])
					return seqPkg::stFetch1;
				return word[20] ? seqPkg::stLdAddr : seqPkg::stStAddr;
			end
			3'b100: begin
				if (word[15:0] == 16'h0000)
					return seqPkg::stFetch1; // Empty register list
				return word[20] ? seqPkg::stLmAddr : seqPkg::stSmAddr;
			end
			3'b101: return word[24] ? seqPkg::stBranchLink : seqPkg::stBranch;
			default: return seqPkg::stFetch1;
		endcase
	endfunction

	function automatic seqPkg::microStateT modelNext(input seqPkg::microStateT s,
		input logic [31:0] word, input logic c, input logic m, input logic last);
		case (s)
			seqPkg::stFetch1: return seqPkg::stFetch2;
			seqPkg::stFetch2: return seqPkg::stFetchWait;
			seqPkg::stFetchWait: return m ? seqPkg::stDecode : seqPkg::stFetchWait;
			seqPkg::stDecode: return decodeTarget(word, c);
			seqPkg::stBranchLink: return seqPkg::stLinkWrite;
			seqPkg::stLdAddr: return seqPkg::stLdCalc;
			seqPkg::stLdCalc: return seqPkg::stLdWait;
			seqPkg::stLdWait: return m ? seqPkg::stLdWrite : seqPkg::stLdWait;
			seqPkg::stStAddr: return seqPkg::stStCalc;
			seqPkg::stStCalc: return seqPkg::stStData;
			seqPkg::stStData: return seqPkg::stStWait;
			seqPkg::stStWait: return m ? seqPkg::stFetch1 : seqPkg::stStWait;
			seqPkg::stLmAddr: return seqPkg::stLmCalc;
			seqPkg::stLmCalc: return seqPkg::stLmWait;
			seqPkg::stLmWait: return m ? seqPkg::stLmNext : seqPkg::stLmWait;
			seqPkg::stLmNext: return last ? seqPkg::stFetch1 : seqPkg::stLmAddr;
			seqPkg::stSmAddr: return seqPkg::stSmCalc;
			seqPkg::stSmCalc: return seqPkg::stSmData;
			seqPkg::stSmData: return seqPkg::stSmWait;
			seqPkg::stSmWait: begin
				if (!m)
					return seqPkg::stSmWait;
				return last ? seqPkg::stFetch1 : seqPkg::stSmAddr;
			end
			default: return seqPkg::stFetch1; // Fetch0 and all one-cycle states
		endcase
	endfunction

	function automatic string behaviorName(input int b);
		case (b)
			1: return "reset and fetch";
			2: return "condition fail and unknown class";
			3: return "data processing";
			4: return "single load and store";
			5: return "load and store multiple";
			default: return "branch and branch with link";
		endcase
	endfunction

	initial begin
		rstN = 1'b0;
		ir = '0;
		cond = 1'b0;
		moc = 1'b0;
		for (int i = 1; i <= 6; i++) begin
			checkCount[i] = 0;
			errorCount[i] = 0;
		end
		expState = seqPkg::stFetch0;
		prevState = seqPkg::stFetch0;
		mask = '0;
		expAddrMode = seqPkg::offset;
		expMultiMode = seqPkg::incAfter;
		{expByte, expSub, expRegOff, expWb} = 4'b0000;
		instrCount = 0;
		curBeh = 1;
		finished = 1'b0;
		repeat (8) @(negedge clk);
		checkValue(1, "state", 32'(state), 32'(seqPkg::stFetch0));
		checkValue(1, "addrMode", 32'(addrMode), 32'(seqPkg::offset));
		checkValue(1, "writeBack", 32'(writeBack), 32'(1'b0));
		checkValue(1, "regNum", 32'(regNum), 32'(4'd0));
		rstN = 1'b1;
		while (!finished) begin
			beh = (prevState inside {seqPkg::stFetch0, seqPkg::stFetch1, seqPkg::stFetch2,
				seqPkg::stFetchWait}) ? 1 : curBeh;
			checkValue(beh, "state", 32'(state), 32'(expState));
			if (expState inside {[seqPkg::stLdAddr:seqPkg::stStWait]}) begin
				checkValue(4, "addrMode", 32'(addrMode), 32'(expAddrMode));
				checkValue(4, "byteOp", 32'(byteOp), 32'(expByte));
				checkValue(4, "subtract", 32'(subtract), 32'(expSub));
				checkValue(4, "regOffset", 32'(regOffset), 32'(expRegOff));
			end
			if (expState inside {[seqPkg::stLmAddr:seqPkg::stSmWait]}) begin
				checkValue(5, "multiMode", 32'(multiMode), 32'(expMultiMode));
				checkValue(5, "writeBack", 32'(writeBack), 32'(expWb));
				if (expState inside {seqPkg::stLmAddr, seqPkg::stSmAddr})
					checkValue(5, "regNum", 32'(regNum), 32'(lowestBit(mask)));
			end
			moc = 1'b0;
			if (expState == seqPkg::stFetch1) begin
				if (instrCount == numInstr) begin
					finished = 1'b1;
				end else begin
					makeInstr(ir, curBeh);
					r = $random(seed);
					cond = (r[1:0] != 2'b00); // Condition passes three times in four
					instrCount++;
				end
			end else if (expState inside {seqPkg::stFetchWait, seqPkg::stLdWait,
				seqPkg::stStWait, seqPkg::stLmWait, seqPkg::stSmWait}) begin
				r = $random(seed);
				moc = r[0];
			end else if (expState == seqPkg::stDecode && !cond) begin
				curBeh = 2;
			end
			if (!finished) begin
				nextExp = modelNext(expState, ir, cond, moc, $countones(mask) == 1);
				if (expState == seqPkg::stDecode && cond) begin
					mask = ir[15:0];
					if (!ir[24])
						expAddrMode = seqPkg::postIndex;
					else
						expAddrMode = ir[21] ? seqPkg::preIndex : seqPkg::offset;
					if (ir[23])
						expMultiMode = ir[24] ? seqPkg::incBefore : seqPkg::incAfter;
					else
						expMultiMode = ir[24] ? seqPkg::decBefore : seqPkg::decAfter;
					expByte = ir[22];
					expSub = !ir[23]; // Down bit clear means subtract
					expRegOff = ir[25];
					expWb = ir[21];
				end
				if ((expState == seqPkg::stLmNext || (expState == seqPkg::stSmWait && moc))
					&& $countones(mask) > 1)
					mask = mask & ~(16'h0001 << lowestBit(mask));
				prevState = expState;
				expState = nextExp;
				@(negedge clk);
			end
		end
		totalChecks = 0;
		totalErrors = 0;
		for (int i = 1; i <= 6; i++) begin
			if (checkCount[i] == 0) begin
				$display("Behavior %0d was never exercised", i);
				errorCount[i]++;
			end
			$display("Behavior %0d %s: %0d checks, %0d errors", i, behaviorName(i),
				checkCount[i], errorCount[i]);
			totalChecks += checkCount[i];
			totalErrors += errorCount[i];
		end
		$display("Instructions %0d, checks %0d, errors %0d", instrCount, totalChecks,
			totalErrors);
		if (totalErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: decodeRegister.sv
`timescale 1ns/10ps

module decodeRegister (
	input logic clk,
	input logic rstN,
	input logic loadFields,
	input logic [seqPkg::irWidth-1:0] ir,
	output seqPkg::addrModeT addrMode,
	output seqPkg::multiModeT multiMode,
	output logic byteOp,
	output logic subtract,
	output logic regOffset,
	output logic writeBack
);

	seqPkg::addrModeT addrModeNext;
	seqPkg::multiModeT multiModeNext;

	always_comb begin
		if (!ir[seqPkg::preBit])
			addrModeNext = seqPkg::postIndex;
		else if (ir[seqPkg::writeBit])
			addrModeNext = seqPkg::preIndex;
		else
			addrModeNext = seqPkg::offset;
		case ({ir[seqPkg::upBit], ir[seqPkg::preBit]})
			2'b10: multiModeNext = seqPkg::incAfter;
			2'b11: multiModeNext = seqPkg::incBefore;
			2'b00: multiModeNext = seqPkg::decAfter;
			default: multiModeNext = seqPkg::decBefore;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			addrMode <= seqPkg::offset;
			multiMode <= seqPkg::incAfter;
			byteOp <= 1'b0;
			subtract <= 1'b0;
			regOffset <= 1'b0;
			writeBack <= 1'b0;
		end else if (loadFields) begin
			addrMode <= addrModeNext;
			multiMode <= multiModeNext;
			byteOp <= ir[seqPkg::byteBit];
			subtract <= !ir[seqPkg::upBit]; // Down means subtract the offset
			regOffset <= ir[seqPkg::classLsb]; // Set for register offset
			writeBack <= ir[seqPkg::writeBit];
		end
	end

endmodule

// File: instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
	input logic [seqPkg::irWidth-1:0] ir,
	output seqPkg::instrClassT instrClass,
	output logic regForm,
	output logic setFlags,
	output logic isLoad
);

	logic [2:0] classField;
	logic [seqPkg::opcodeMsb-seqPkg::opcodeLsb:0] opcode;
	logic isTest;

	assign classField = ir[seqPkg::classMsb:seqPkg::classLsb];
	assign opcode = ir[seqPkg::opcodeMsb:seqPkg::opcodeLsb];
	assign isTest = (opcode == seqPkg::tstOpcode) || (opcode == seqPkg::teqOpcode);

	assign setFlags = ir[seqPkg::sBit];
	assign isLoad = ir[seqPkg::loadBit];

	always_comb begin
		instrClass = seqPkg::clsUnknown;
		regForm = 1'b0;
		case (classField)
			seqPkg::dpRegCode: begin
				if (ir[seqPkg::shiftRegBit]) begin
					instrClass = seqPkg::clsUnknown; // Shift by register or extra load and store
				end else begin
					regForm = 1'b1;
					instrClass = isTest ? seqPkg::clsTest : seqPkg::clsDpReg;
				end
			end
			seqPkg::dpImmCode: begin
				instrClass = isTest ? seqPkg::clsTest : seqPkg::clsDpImm;
			end
			seqPkg::lsImmCode: begin
				instrClass = seqPkg::clsLoadStore;
			end
			seqPkg::lsRegCode: begin
				if (!ir[seqPkg::shiftRegBit]) begin
					regForm = 1'b1;
					instrClass = seqPkg::clsLoadStore;
				end
			end
			seqPkg::multiCode: begin
				instrClass = seqPkg::clsMulti;
			end
			seqPkg::branchCode: begin
				// For a branch the form flag selects the link variant
				regForm = ir[seqPkg::linkBit];
				instrClass = seqPkg::clsBranch;
			end
			default: begin
				instrClass = seqPkg::clsUnknown;
			end
		endcase
	end

endmodule

// File: microSequencer.sv
`timescale 1ns/10ps

module microSequencer (
	input logic clk,
	input logic rstN,
	input logic cond,
	input logic moc,
	input seqPkg::instrClassT instrClass,
	input logic regForm,
	input logic setFlags,
	input logic isLoad,
	input logic listEmpty,
	input logic lastReg,
	output seqPkg::microStateT state,
	output logic loadFields,
	output logic advance
);

	seqPkg::microStateT nextState;

	always_ff @(posedge clk) begin
		if (!rstN)
			state <= seqPkg::stFetch0;
		else
			state <= nextState;
	end

	assign loadFields = (state == seqPkg::stDecode) && cond;

	assign advance = ((state == seqPkg::stLmNext) && !lastReg) ||
		((state == seqPkg::stSmWait) && moc && !lastReg);

	always_comb begin
		nextState = seqPkg::stFetch1;
		case (state)
			seqPkg::stFetch0: nextState = seqPkg::stFetch1;
			seqPkg::stFetch1: nextState = seqPkg::stFetch2;
			seqPkg::stFetch2: nextState = seqPkg::stFetchWait;
			seqPkg::stFetchWait: nextState = moc ? seqPkg::stDecode : seqPkg::stFetchWait;
			seqPkg::stDecode: begin
				if (!cond) begin
					nextState = seqPkg::stFetch1; // Condition failed
				end else begin
					case (instrClass)
						seqPkg::clsDpImm:
							nextState = setFlags ? seqPkg::stDpImmS : seqPkg::stDpImm;
						seqPkg::clsDpReg:
							nextState = setFlags ? seqPkg::stDpRegS : seqPkg::stDpReg;
						seqPkg::clsTest:
							nextState = regForm ? seqPkg::stTestReg : seqPkg::stTestImm;
						seqPkg::clsLoadStore:
							nextState = isLoad ? seqPkg::stLdAddr : seqPkg::stStAddr;
						seqPkg::clsMulti: begin
							if (listEmpty)
								nextState = seqPkg::stFetch1; // Nothing to transfer
							else
								nextState = isLoad ? seqPkg::stLmAddr : seqPkg::stSmAddr;
						end
						seqPkg::clsBranch:
							nextState = regForm ? seqPkg::stBranchLink : seqPkg::stBranch;
						default: nextState = seqPkg::stFetch1; // Unknown instruction
					endcase
				end
			end

			// Single cycle operations
			seqPkg::stDpImm, seqPkg::stDpImmS, seqPkg::stDpReg, seqPkg::stDpRegS,
			seqPkg::stTestImm, seqPkg::stTestReg, seqPkg::stBranch:
				nextState = seqPkg::stFetch1;
			seqPkg::stBranchLink: nextState = seqPkg::stLinkWrite;
			seqPkg::stLinkWrite: nextState = seqPkg::stFetch1;

			seqPkg::stLdAddr: nextState = seqPkg::stLdCalc;
			seqPkg::stLdCalc: nextState = seqPkg::stLdWait;
			seqPkg::stLdWait: nextState = moc ? seqPkg::stLdWrite : seqPkg::stLdWait;
			seqPkg::stLdWrite: nextState = seqPkg::stFetch1;

			seqPkg::stStAddr: nextState = seqPkg::stStCalc;
			seqPkg::stStCalc: nextState = seqPkg::stStData;
			seqPkg::stStData: nextState = seqPkg::stStWait;
			seqPkg::stStWait: nextState = moc ? seqPkg::stFetch1 : seqPkg::stStWait;

			seqPkg::stLmAddr: nextState = seqPkg::stLmCalc;
			seqPkg::stLmCalc: nextState = seqPkg::stLmWait;
			seqPkg::stLmWait: nextState = moc ? seqPkg::stLmNext : seqPkg::stLmWait;
			seqPkg::stLmNext: nextState = lastReg ? seqPkg::stFetch1 : seqPkg::stLmAddr;

			seqPkg::stSmAddr: nextState = seqPkg::stSmCalc;
			seqPkg::stSmCalc: nextState = seqPkg::stSmData;
			seqPkg::stSmData: nextState = seqPkg::stSmWait;
			seqPkg::stSmWait: begin
				if (!moc)
					nextState = seqPkg::stSmWait; // Memory still busy
				else if (lastReg)
					nextState = seqPkg::stFetch1;
				else
					nextState = seqPkg::stSmAddr;
			end

			default: nextState = seqPkg::stFetch1;
		endcase
	end

endmodule

// File: regListScanner.sv
`timescale 1ns/10ps

module regListScanner (
	input logic clk,
	input logic rstN,
	input logic loadFields,
	input logic advance,
	input logic [seqPkg::irWidth-1:0] ir,
	output logic [seqPkg::regNumWidth-1:0] regNum,
	output logic listEmpty,
	output logic lastReg
);

	logic [seqPkg::regListWidth-1:0] listMask; // Registers still to transfer
	logic [seqPkg::regListWidth-1:0] remaining;

	assign remaining = listMask & (listMask - 1'b1); // Lowest set bit removed

	always_ff @(posedge clk) begin
		if (!rstN) begin
			listMask <= '0;
		end else if (loadFields) begin
			listMask <= ir[seqPkg::regListWidth-1:0];
		end else if (advance) begin
			listMask <= remaining;
		end
	end

	// Lowest remaining register, so transfers go in ascending order
	always_comb begin
		regNum = '0;
		for (int i = seqPkg::regListWidth - 1; i >= 0; i--) begin
			if (listMask[i])
				regNum = seqPkg::regNumWidth'(i);
		end
	end

	// Looked at during decode, before the mask is loaded
	assign listEmpty = ~|ir[seqPkg::regListWidth-1:0];

	assign lastReg = (|listMask) & ~(|remaining); // One register left

endmodule

// File: run.sh
#!/bin/sh
# Build and run the sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f controlSequencer.f \
	--top-module controlSequencerTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VcontrolSequencerTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

// File: seqPkg.sv
package seqPkg;

	localparam int irWidth = 32;
	localparam int regListWidth = 16;
	localparam int regNumWidth = 4;

	// Instruction field positions
	localparam int classLsb = 25;
	localparam int classMsb = 27;
	localparam int preBit = 24;
	localparam int linkBit = 24; // Same bit as pre, branch only
	localparam int upBit = 23;
	localparam int byteBit = 22;
	localparam int writeBit = 21;
	localparam int loadBit = 20;
	localparam int sBit = 20; // Data processing flag update
	localparam int extraLsBit = 7;
	localparam int shiftRegBit = 4;
	localparam int opcodeLsb = 21;
	localparam int opcodeMsb = 24;

	// Values of the class field, bits 27:25
	localparam logic [2:0] dpRegCode = 3'b000;
	localparam logic [2:0] dpImmCode = 3'b001;
	localparam logic [2:0] lsImmCode = 3'b010;
	localparam logic [2:0] lsRegCode = 3'b011;
	localparam logic [2:0] multiCode = 3'b100;
	localparam logic [2:0] branchCode = 3'b101;

	localparam logic [3:0] tstOpcode = 4'b1000;
	localparam logic [3:0] teqOpcode = 4'b1001;

	typedef enum logic [2:0] {
		clsDpImm, clsDpReg, clsTest, clsLoadStore, clsMulti, clsBranch, clsUnknown
	} instrClassT;

	typedef enum logic [5:0] {
		stFetch0, stFetch1, stFetch2, stFetchWait, stDecode,
		stDpImm, stDpImmS, stDpReg, stDpRegS, stTestImm, stTestReg,
		stLdAddr, stLdCalc, stLdWait, stLdWrite,
		stStAddr, stStCalc, stStData, stStWait,
		stLmAddr, stLmCalc, stLmWait, stLmNext,
		stSmAddr, stSmCalc, stSmData, stSmWait,
		stBranch, stBranchLink, stLinkWrite
	} microStateT;

	typedef enum logic [1:0] {
		offset, preIndex, postIndex
	} addrModeT;

	typedef enum logic [1:0] {
		incAfter, incBefore, decAfter, decBefore
	} multiModeT;

endpackage
